//--- src.f
hdl/spmm_pkg.sv
hdl/feature_reader.sv
hdl/node_info_fifo.sv
hdl/weight_bank.sv
hdl/sparse_pe.sv
hdl/wh_writer.sv
hdl/spmm_top.sv
test/tb_spmm.sv

//--- test/tb_spmm.sv
// testbench for the sparse feature x weight stage
// - clock, reset, LCG driven weights and graph
// - node-info and feature memory models, Wh capture
// - reference sums and assertion based checks
// - two runs, the second with new weights and length-1 rows

`timescale 1ns/10ps
`default_nettype none

module tb_spmm;

  localparam int N_ROWS1 = 12;
  localparam int N_ROWS2 = 10;
  localparam int TIMEOUT = 2000;

  logic                                   clk = 1'b0;
  logic                                   rst_n;
  logic                                   start_i;
  spmm_pkg::info_addr_t                   num_rows_i;
  logic                                   busy_o;
  logic                                   done_o;
  logic                                   info_re_o;
  spmm_pkg::info_addr_t                   info_addr_o;
  spmm_pkg::node_info_t                   info_rdata_i = '0;
  logic                                   feat_re_o;
  spmm_pkg::feat_addr_t                   feat_addr_o;
  spmm_pkg::feat_entry_t                  feat_rdata_i = '0;
  logic                                   wgt_we_i;
  spmm_pkg::col_idx_t                     wgt_addr_i;
  spmm_pkg::data_t [spmm_pkg::W_COLS-1:0] wgt_din_i;
  logic                                   wh_we_o;
  spmm_pkg::wh_addr_t                     wh_addr_o;
  spmm_pkg::wh_word_t                     wh_wdata_o;

  logic [31:0]           rng = 32'h51f0;
  spmm_pkg::node_info_t  info_mem [64];
  spmm_pkg::feat_entry_t feat_mem [1024];
  spmm_pkg::data_t       w_ref [64][spmm_pkg::W_COLS];
  int                    exp_sum [64][spmm_pkg::W_COLS];
  spmm_pkg::wh_word_t    wh_cap [64];
  // monitor counters run freely, each run keeps its own base
  int                    info_cnt = 0;
  int                    feat_cnt = 0;
  int                    wr_cnt = 0;
  int                    done_cnt = 0;
  int                    info_base;
  int                    feat_base;
  int                    wr_base;
  int                    done_base;
  int                    n_ent;
  int                    cur_rows;
  int                    errors = 0;
  int                    checks = 0;
  logic                  prev_busy = 1'b0;
  logic                  prev_done = 1'b0;

  spmm_top u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .num_rows_i   (num_rows_i),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .info_re_o    (info_re_o),
    .info_addr_o  (info_addr_o),
    .info_rdata_i (info_rdata_i),
    .feat_re_o    (feat_re_o),
    .feat_addr_o  (feat_addr_o),
    .feat_rdata_i (feat_rdata_i),
    .wgt_we_i     (wgt_we_i),
    .wgt_addr_i   (wgt_addr_i),
    .wgt_din_i    (wgt_din_i),
    .wh_we_o      (wh_we_o),
    .wh_addr_o    (wh_addr_o),
    .wh_wdata_o   (wh_wdata_o)
  );

  always #4 clk = ~clk;

  // external memories, data one cycle after the read
  always @(posedge clk) begin
    if (info_re_o) begin
      info_rdata_i <= info_mem[info_addr_o];
    end
    if (feat_re_o) begin
      feat_rdata_i <= feat_mem[feat_addr_o];
    end
  end

  function automatic logic [31:0] next_rand();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng;
  endfunction

  task automatic check_val(input string name, input int expd, input int act);
    checks++;
    assert (expd == act)
    else begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, expd, act);
      errors++;
    end
  endtask

  // ============================================================
  // monitor, sampled away from the driving edge
  // ============================================================
  always @(negedge clk) begin
    if (!rst_n) begin
      check_val("reset wh_we_o", 0, wh_we_o);
      check_val("reset done_o", 0, done_o);
      check_val("reset feat_re_o", 0, feat_re_o);
      check_val("reset info_re_o", 0, info_re_o);
      check_val("reset busy_o", 0, busy_o);
    end else begin
      if (info_re_o) begin
        check_val("info address", info_cnt - info_base, info_addr_o);
        info_cnt++;
      end
      if (feat_re_o) begin
        check_val("feature address", feat_cnt - feat_base, feat_addr_o);
        feat_cnt++;
      end
      if (wh_we_o) begin
        check_val("wh address", wr_cnt - wr_base, wh_addr_o);
        check_val("done with last write", (wr_cnt - wr_base) == cur_rows - 1, done_o);
        wh_cap[wh_addr_o] = wh_wdata_o;
        wr_cnt++;
      end
      if (done_o) begin
        check_val("busy at done", 1, busy_o);
        check_val("done pulse width", 0, prev_done);
        done_cnt++;
      end
      if (prev_busy && !busy_o) begin
        check_val("busy drop after done", 1, prev_done);
      end
    end
    prev_busy = busy_o;
    prev_done = done_o;
  end

  task automatic load_weights();
    spmm_pkg::data_t [spmm_pkg::W_COLS-1:0] din;
    for (int a = 0; a < 64; a++) begin
      for (int c = 0; c < spmm_pkg::W_COLS; c++) begin
        din[c]      = spmm_pkg::data_t'(next_rand() >> 16);
        w_ref[a][c] = din[c];
      end
      @(posedge clk);
      wgt_we_i   <= 1'b1;
      wgt_addr_i <= spmm_pkg::col_idx_t'(a);
      wgt_din_i  <= din;
    end
    @(posedge clk);
    wgt_we_i <= 1'b0;
  endtask

  // fills both memories and the reference sums
  task automatic build_graph(input int nrows, input bit unit_len);
    int len;
    n_ent = 0;
    for (int r = 0; r < nrows; r++) begin
      len = unit_len ? 1 : 1 + int'((next_rand() >> 16) % 6);
      info_mem[r].row_len   = spmm_pkg::row_len_t'(len);
      info_mem[r].num_nodes = spmm_pkg::num_node_t'(next_rand() >> 16);
      info_mem[r].src_flag  = next_rand() > 32'h8000_0000;
      for (int j = 0; j < spmm_pkg::W_COLS; j++) begin
        exp_sum[r][j] = 0;
      end
      for (int e = 0; e < len; e++) begin
        feat_mem[n_ent].col_idx = spmm_pkg::col_idx_t'(next_rand() >> 16);
        feat_mem[n_ent].val     = spmm_pkg::data_t'(next_rand() >> 16);
        for (int j = 0; j < spmm_pkg::W_COLS; j++) begin
          exp_sum[r][j] += int'(feat_mem[n_ent].val) *
                           int'(w_ref[feat_mem[n_ent].col_idx][j]);
        end
        n_ent++;
      end
    end
  endtask

  task automatic run_graph(input int nrows, input bit extra_start);
    int             cyc;
    spmm_pkg::acc_t s;
    info_base = info_cnt;
    feat_base = feat_cnt;
    wr_base   = wr_cnt;
    done_base = done_cnt;
    cur_rows  = nrows;
    @(posedge clk);
    start_i    <= 1'b1;
    num_rows_i <= spmm_pkg::info_addr_t'(nrows);
    @(posedge clk);
    start_i <= 1'b0;
    @(negedge clk);
    check_val("busy after start", 1, busy_o);
    if (extra_start) begin
      // start while busy, must change nothing
      repeat (5) @(posedge clk);
      start_i    <= 1'b1;
      num_rows_i <= spmm_pkg::info_addr_t'(2);
      @(posedge clk);
      start_i <= 1'b0;
    end
    cyc = 0;
    while (done_cnt == done_base && cyc < TIMEOUT) begin
      @(posedge clk);
      cyc++;
    end
    if (done_cnt == done_base) begin
      $display("timeout: no done_o within %0d cycles of the start", TIMEOUT);
      errors++;
    end
    // room for a stray write after done
    repeat (4) @(posedge clk);
    check_val("done count", 1, done_cnt - done_base);
    check_val("wh write count", nrows, wr_cnt - wr_base);
    check_val("info read count", nrows, info_cnt - info_base);
    check_val("feature read count", n_ent, feat_cnt - feat_base);
    for (int r = 0; r < nrows; r++) begin
      for (int j = 0; j < spmm_pkg::W_COLS; j++) begin
        s = wh_cap[r].sums[j];
        check_val($sformatf("row %0d sum %0d", r, j), exp_sum[r][j], s);
      end
      check_val($sformatf("row %0d num_nodes", r), info_mem[r].num_nodes,
                wh_cap[r].num_nodes);
      check_val($sformatf("row %0d src_flag", r), info_mem[r].src_flag,
                wh_cap[r].src_flag);
    end
  endtask

  // ============================================================
  // main sequence
  // ============================================================
  initial begin
    rst_n      = 1'b0;
    start_i    = 1'b0;
    num_rows_i = '0;
    wgt_we_i   = 1'b0;
    wgt_addr_i = '0;
    wgt_din_i  = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    load_weights();
    build_graph(N_ROWS1, 1'b0);
    run_graph(N_ROWS1, 1'b0);

    // new W, then a run of single-entry rows
    load_weights();
    build_graph(N_ROWS2, 1'b1);
    run_graph(N_ROWS2, 1'b1);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/spmm_top.sv
// top of the feature x weight stage, Wh = H x W
// - feature reader and node info FIFO
// - one weight bank and one PE per output column
// - Wh writer

`timescale 1ns/10ps
`default_nettype none

module spmm_top (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   start_i,
  input  spmm_pkg::info_addr_t                   num_rows_i,
  output logic                                   busy_o,
  output logic                                   done_o,
  output logic                                   info_re_o,
  output spmm_pkg::info_addr_t                   info_addr_o,
  input  spmm_pkg::node_info_t                   info_rdata_i,
  output logic                                   feat_re_o,
  output spmm_pkg::feat_addr_t                   feat_addr_o,
  input  spmm_pkg::feat_entry_t                  feat_rdata_i,
  input  logic                                   wgt_we_i,
  input  spmm_pkg::col_idx_t                     wgt_addr_i,
  input  spmm_pkg::data_t [spmm_pkg::W_COLS-1:0] wgt_din_i,
  output logic                                   wh_we_o,
  output spmm_pkg::wh_addr_t                     wh_addr_o,
  output spmm_pkg::wh_word_t                     wh_wdata_o
);

  spmm_pkg::pe_beat_t                    beat;
  spmm_pkg::col_idx_t                    wgt_raddr;
  spmm_pkg::data_t [spmm_pkg::W_COLS-1:0] wgt_rd;
  spmm_pkg::acc_t [spmm_pkg::W_COLS-1:0]  pe_res;
  logic [spmm_pkg::W_COLS-1:0]           pe_vld;
  logic                                  push;
  spmm_pkg::info_entry_t                 push_data;
  logic                                  pop;
  spmm_pkg::info_entry_t                 head;

  feature_reader u_reader (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .num_rows_i   (num_rows_i),
    .done_i       (done_o),
    .info_re_o    (info_re_o),
    .info_addr_o  (info_addr_o),
    .info_rdata_i (info_rdata_i),
    .feat_re_o    (feat_re_o),
    .feat_addr_o  (feat_addr_o),
    .feat_rdata_i (feat_rdata_i),
    .wgt_raddr_o  (wgt_raddr),
    .beat_o       (beat),
    .push_o       (push),
    .push_data_o  (push_data),
    .busy_o       (busy_o)
  );

  node_info_fifo u_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .pop_data_o  (head),
    .empty_o     ()
  );

  // ============================================================
  // one bank and one PE per output column
  // ============================================================
  for (genvar c = 0; c < spmm_pkg::W_COLS; c++) begin : g_col
    weight_bank u_bank (
      .clk     (clk),
      .we_i    (wgt_we_i),
      .waddr_i (wgt_addr_i),
      .wdata_i (wgt_din_i[c]),
      .raddr_i (wgt_raddr),
      .rdata_o (wgt_rd[c])
    );

    sparse_pe u_pe (
      .clk       (clk),
      .rst_n     (rst_n),
      .beat_i    (beat),
      .wgt_i     (wgt_rd[c]),
      .res_o     (pe_res[c]),
      .res_vld_o (pe_vld[c])
    );
  end

  // all PEs run in lockstep, PE 0 strobes the write
  wh_writer u_writer (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (start_i),
    .res_i      (pe_res),
    .res_vld_i  (pe_vld[0]),
    .pop_o      (pop),
    .head_i     (head),
    .wh_we_o    (wh_we_o),
    .wh_addr_o  (wh_addr_o),
    .wh_wdata_o (wh_wdata_o),
    .done_o     (done_o)
  );

endmodule

`default_nettype wire

//--- hdl/wh_writer.sv
// output side of the sparse multiply
// - packs the column sums with num_nodes and src_flag
// - FIFO pop and Wh write on the PE result strobe
// - Wh address counter and done pulse

`timescale 1ns/10ps
`default_nettype none

module wh_writer (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    start_i,
  input  spmm_pkg::acc_t [spmm_pkg::W_COLS-1:0]   res_i,
  input  logic                                    res_vld_i,
  output logic                                    pop_o,
  input  spmm_pkg::info_entry_t                   head_i,
  output logic                                    wh_we_o,
  output spmm_pkg::wh_addr_t                      wh_addr_o,
  output spmm_pkg::wh_word_t                      wh_wdata_o,
  output logic                                    done_o
);

  // a start is only taken between runs
  logic               run_q;
  spmm_pkg::wh_addr_t addr_q;

  assign pop_o     = res_vld_i;
  assign wh_we_o   = res_vld_i;
  assign wh_addr_o = addr_q;
  assign done_o    = res_vld_i & head_i.last_row;

  always_comb begin
    wh_wdata_o.sums      = res_i;
    wh_wdata_o.num_nodes = head_i.info.num_nodes;
    wh_wdata_o.src_flag  = head_i.info.src_flag;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q  <= 1'b0;
      addr_q <= '0;
    end else begin
      if (start_i && !run_q) begin
        run_q  <= 1'b1;
        addr_q <= '0;
      end else if (res_vld_i) begin
        addr_q <= addr_q + 1'b1;
        if (head_i.last_row) begin
          run_q <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/sparse_pe.sv
// processing element for one output column
// - signed product of entry value and weight
// - row accumulator, restarted on the first beat
// - result and one-cycle valid after the last beat

`timescale 1ns/10ps
`default_nettype none

module sparse_pe (
  input  logic               clk,
  input  logic               rst_n,
  input  spmm_pkg::pe_beat_t beat_i,
  input  spmm_pkg::data_t    wgt_i,
  output spmm_pkg::acc_t     res_o,
  output logic               res_vld_o
);

  spmm_pkg::acc_t prod;
  spmm_pkg::acc_t acc;
  spmm_pkg::acc_t acc_nxt;

  // operands sign extended to the sum width
  assign prod    = beat_i.val * wgt_i;
  assign acc_nxt = beat_i.first ? prod : acc + prod;

  always_ff @(posedge clk) begin
    if (beat_i.vld) begin
      acc <= acc_nxt;
    end
    // hold the row sum so the next row can start right away
    if (beat_i.vld && beat_i.last) begin
      res_o <= acc_nxt;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_vld_o <= 1'b0;
    end else begin
      res_vld_o <= beat_i.vld & beat_i.last;
    end
  end

endmodule

`default_nettype wire

//--- hdl/weight_bank.sv
// one column of W
// - write port for loading before a run
// - registered read addressed by the feature column index

`timescale 1ns/10ps
`default_nettype none

module weight_bank (
  input  logic               clk,
  input  logic               we_i,
  input  spmm_pkg::col_idx_t waddr_i,
  input  spmm_pkg::data_t    wdata_i,
  input  spmm_pkg::col_idx_t raddr_i,
  output spmm_pkg::data_t    rdata_o
);

  spmm_pkg::data_t mem [spmm_pkg::WGT_DEPTH];

  // load path
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // read data valid one cycle after raddr_i
  always_ff @(posedge clk) begin
    rdata_o <= mem[raddr_i];
  end

endmodule

`default_nettype wire

//--- hdl/node_info_fifo.sv
// node info FIFO between reader and writer
// - register array with read and write pointers
// - head of the FIFO shown on pop_data_o

`timescale 1ns/10ps
`default_nettype none

module node_info_fifo (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  push_i,
  input  spmm_pkg::info_entry_t push_data_i,
  input  logic                  pop_i,
  output spmm_pkg::info_entry_t pop_data_o,
  output logic                  empty_o
);

  spmm_pkg::info_entry_t mem [spmm_pkg::FIFO_DEPTH];
  // extra msb tells full from empty
  logic [spmm_pkg::FIFO_AW:0] wr_ptr;
  logic [spmm_pkg::FIFO_AW:0] rd_ptr;

  assign empty_o    = (wr_ptr == rd_ptr);
  assign pop_data_o = mem[rd_ptr[spmm_pkg::FIFO_AW-1:0]];

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr[spmm_pkg::FIFO_AW-1:0]] <= push_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_i && !empty_o) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/feature_reader.sv
// input side of the sparse multiply
// - FSM over node-info words and feature entries
// - feature address running across all rows of a run
// - beat pipeline aligned with the weight bank read
// - FIFO push of row info, busy flag

`timescale 1ns/10ps
`default_nettype none

module feature_reader (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start_i,
  input  spmm_pkg::info_addr_t     num_rows_i,
  input  logic                     done_i,
  output logic                     info_re_o,
  output spmm_pkg::info_addr_t     info_addr_o,
  input  spmm_pkg::node_info_t     info_rdata_i,
  output logic                     feat_re_o,
  output spmm_pkg::feat_addr_t     feat_addr_o,
  input  spmm_pkg::feat_entry_t    feat_rdata_i,
  output spmm_pkg::col_idx_t       wgt_raddr_o,
  output spmm_pkg::pe_beat_t       beat_o,
  output logic                     push_o,
  output spmm_pkg::info_entry_t    push_data_o,
  output logic                     busy_o
);

  spmm_pkg::reader_state_t state;
  spmm_pkg::info_addr_t    row_cnt;
  spmm_pkg::info_addr_t    last_row_idx;
  spmm_pkg::row_len_t      remain;
  spmm_pkg::feat_addr_t    feat_addr;
  spmm_pkg::info_entry_t   cur_row;
  logic                    first_ent;
  // stage 1, feature data on the bus
  logic                    rd_vld_q;
  logic                    first_q;
  logic                    last_q;

  assign info_re_o   = (state == spmm_pkg::INFO_REQ);
  assign info_addr_o = row_cnt;
  assign feat_re_o   = (state == spmm_pkg::ENTRIES);
  assign feat_addr_o = feat_addr;
  // weight banks read in the same cycle the entry arrives
  assign wgt_raddr_o = feat_rdata_i.col_idx;

  // ============================================================
  // row / entry FSM
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= spmm_pkg::IDLE;
      row_cnt      <= '0;
      last_row_idx <= '0;
      remain       <= '0;
      feat_addr    <= '0;
      first_ent    <= 1'b0;
      busy_o       <= 1'b0;
    end else begin
      if (start_i && !busy_o) begin
        busy_o <= 1'b1;
      end else if (done_i) begin
        busy_o <= 1'b0;
      end
      case (state)
        spmm_pkg::IDLE: begin
          if (start_i && !busy_o) begin
            state        <= spmm_pkg::INFO_REQ;
            row_cnt      <= '0;
            last_row_idx <= num_rows_i - 1'b1;
            feat_addr    <= '0;
          end
        end
        spmm_pkg::INFO_REQ: state <= spmm_pkg::INFO_WAIT;
        spmm_pkg::INFO_WAIT: begin
          remain    <= info_rdata_i.row_len;
          first_ent <= 1'b1;
          state     <= spmm_pkg::ENTRIES;
        end
        spmm_pkg::ENTRIES: begin
          feat_addr <= feat_addr + 1'b1;
          remain    <= remain - 1'b1;
          first_ent <= 1'b0;
          if (remain == 1) begin
            if (row_cnt == last_row_idx) begin
              state <= spmm_pkg::IDLE;
            end else begin
              row_cnt <= row_cnt + 1'b1;
              state   <= spmm_pkg::INFO_REQ;
            end
          end
        end
        default: state <= spmm_pkg::IDLE;
      endcase
    end
  end

  // row info, held until the first beat pushes it
  always_ff @(posedge clk) begin
    if (state == spmm_pkg::INFO_WAIT) begin
      cur_row.info     <= info_rdata_i;
      cur_row.last_row <= (row_cnt == last_row_idx);
    end
    if (rd_vld_q && first_q) begin
      push_data_o <= cur_row;
    end
  end

  // ============================================================
  // beat pipeline
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_vld_q <= 1'b0;
      first_q  <= 1'b0;
      last_q   <= 1'b0;
      beat_o   <= '0;
      push_o   <= 1'b0;
    end else begin
      rd_vld_q     <= (state == spmm_pkg::ENTRIES);
      first_q      <= first_ent;
      last_q       <= (remain == 1);
      // delay one more cycle to meet the registered weight read
      beat_o.vld   <= rd_vld_q;
      beat_o.val   <= feat_rdata_i.val;
      beat_o.first <= rd_vld_q & first_q;
      beat_o.last  <= rd_vld_q & last_q;
      push_o       <= rd_vld_q & first_q;
    end
  end

endmodule

`default_nettype wire

//--- hdl/spmm_pkg.sv
// shared definitions for the sparse feature x weight stage
// - column count, FIFO depth, weight memory depth
// - vector types for values, sums, indices and addresses
// - memory word, PE beat, FIFO entry and Wh word structs
// - reader FSM states

`default_nettype none

package spmm_pkg;

  // ============================================================
  // sizes
  // ============================================================
  localparam int W_COLS     = 4;
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
  localparam int WGT_DEPTH  = 64;

  // ============================================================
  // vector types
  // ============================================================
  typedef logic signed [7:0]  data_t;
  typedef logic signed [23:0] acc_t;
  typedef logic [5:0]         col_idx_t;
  typedef logic [5:0]         row_len_t;
  typedef logic [7:0]         num_node_t;
  typedef logic [9:0]         feat_addr_t;
  typedef logic [5:0]         info_addr_t;
  typedef logic [5:0]         wh_addr_t;

  // ============================================================
  // structs
  // ============================================================
  // one word of the feature memory
  typedef struct packed {
    col_idx_t col_idx;
    data_t    val;
  } feat_entry_t;

  // one word of the node-info memory
  typedef struct packed {
    row_len_t  row_len;
    num_node_t num_nodes;
    logic      src_flag;
  } node_info_t;

  // non-zero entry on its way to the PEs
  typedef struct packed {
    logic  vld;
    data_t val;
    logic  first;
    logic  last;
  } pe_beat_t;

  typedef struct packed {
    node_info_t info;
    logic       last_row;
  } info_entry_t;

  // sums[0] is output column 0
  typedef struct packed {
    acc_t [W_COLS-1:0] sums;
    num_node_t         num_nodes;
    logic              src_flag;
  } wh_word_t;

  typedef enum logic [1:0] {
    IDLE,
    INFO_REQ,
    INFO_WAIT,
    ENTRIES
  } reader_state_t;

endpackage

`default_nettype wire
